//--- fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// first fetch address out of reset
`define RESET_PC 32'h0000_0100

// queue entries, equal to the fetch credits held by pc_gen
`define IQ_DEPTH 4

// consumer credits held by the queue after reset
`define OUT_CREDITS 2

// primary opcodes sorted by predecode
`define OP_J   6'd2
`define OP_JAL 6'd3
`define OP_BEQ 6'd4
`define OP_BNE 6'd5

`endif

//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// one fetched word, read either as i-type or j-type
	typedef union packed {
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i_form;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] target;
		} j_form;
	} instr_word_u;

	// how the front end sorted an instruction
	typedef enum logic [1:0] {
		KIND_SEQ    = 2'd0,
		KIND_JUMP   = 2'd1,
		KIND_BRANCH = 2'd2
	} instr_kind_e;

endpackage

`default_nettype wire

//--- iq_push_if.sv
`timescale 1ns/1ps
`default_nettype none

// one predecoded instruction per cycle, always accepted by the queue
interface iq_push_if
	import fetch_pkg::*;
();

	logic        push;
	logic [31:0] pc;
	instr_word_u instr;
	instr_kind_e kind;

	modport source (
		output push,
		output pc,
		output instr,
		output kind
	);

	modport sink (
		input push,
		input pc,
		input instr,
		input kind
	);

endinterface

`default_nettype wire

//--- pc_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module pc_gen (
	input  logic        clk,
	input  logic        reset,
	input  logic        redirect_valid,
	input  logic [31:0] redirect_pc,
	input  logic        jump_valid,
	input  logic [31:0] jump_target,
	input  logic        fetch_credit,
	output logic        req_valid,
	output logic [31:0] req_pc
);

	localparam int CW = $clog2(`IQ_DEPTH + 1);

	logic [31:0]   pc;
	logic [CW-1:0] credits;
	// low until the first cycle after reset
	logic          active;

	// jump and redirect both steal the slot, so no wrong-path request goes out
	assign req_valid = active && (credits != '0) && !redirect_valid && !jump_valid;
	assign req_pc    = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
		end else begin
			active <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc      <= `RESET_PC;
			credits <= CW'(`IQ_DEPTH);
		end else if (redirect_valid) begin
			// queue is flushed too, so every slot is free again
			pc      <= redirect_pc;
			credits <= CW'(`IQ_DEPTH);
		end else if (jump_valid) begin
			pc      <= jump_target;
			credits <= credits + CW'(fetch_credit);
		end else begin
			if (req_valid) begin
				pc <= pc + 32'd4;
			end
			credits <= credits - CW'(req_valid) + CW'(fetch_credit);
		end
	end

endmodule

`default_nettype wire

//--- predecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module predecode
	import fetch_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        redirect_valid,
	input  logic        req_valid,
	input  logic [31:0] req_pc,
	input  instr_word_u imem_data,
	output logic        jump_valid,
	output logic [31:0] jump_target,
	iq_push_if.source   push_port
);

	// request delayed one cycle to meet the memory response
	logic        resp_valid;
	logic [31:0] resp_pc;
	logic [31:0] pc_plus4;
	logic        is_jump;
	logic        is_branch;
	logic        push;

	always_ff @(posedge clk) begin
		if (reset) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= req_valid;
		end
	end

	// pc only matters while resp_valid is set
	always_ff @(posedge clk) begin
		resp_pc <= req_pc;
	end

	assign pc_plus4 = resp_pc + 32'd4;

	always_comb begin
		is_jump   = (imem_data.j_form.opcode == `OP_J) ||
		            (imem_data.j_form.opcode == `OP_JAL);
		is_branch = (imem_data.i_form.opcode == `OP_BEQ) ||
		            (imem_data.i_form.opcode == `OP_BNE);
	end

	// a redirect kills the response still in flight
	assign push = resp_valid && !redirect_valid;

	// region of the delay-slot address, then word index
	assign jump_target = {pc_plus4[31:28], imem_data.j_form.target, 2'b00};
	assign jump_valid  = push && is_jump;

	always_comb begin
		push_port.push  = push;
		push_port.pc    = resp_pc;
		push_port.instr = imem_data;
		if (is_jump) begin
			push_port.kind = KIND_JUMP;
		end else if (is_branch) begin
			// no prediction, branches just fall through
			push_port.kind = KIND_BRANCH;
		end else begin
			push_port.kind = KIND_SEQ;
		end
	end

endmodule

`default_nettype wire

//--- instr_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module instr_queue
	import fetch_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        redirect_valid,
	iq_push_if.sink     push_port,
	output logic        fetch_credit,
	output logic        out_valid,
	output logic [31:0] out_pc,
	output logic [31:0] out_instr,
	output instr_kind_e out_kind,
	input  logic        out_credit
);

	localparam int PW  = (`IQ_DEPTH > 1) ? $clog2(`IQ_DEPTH) : 1;
	localparam int CW  = $clog2(`IQ_DEPTH + 1);
	localparam int OCW = $clog2(`OUT_CREDITS + 1);

	logic [31:0]    q_pc    [`IQ_DEPTH];
	instr_word_u    q_instr [`IQ_DEPTH];
	instr_kind_e    q_kind  [`IQ_DEPTH];
	logic [PW-1:0]  wr_ptr;
	logic [PW-1:0]  rd_ptr;
	logic [CW-1:0]  count;
	logic [OCW-1:0] out_credits;
	logic           pop;

	// no pop in a flush cycle, the entries are dropped instead
	assign pop          = (count != '0) && (out_credits != '0) && !redirect_valid;
	assign fetch_credit = pop;

	always_ff @(posedge clk) begin
		if (push_port.push) begin
			q_pc[wr_ptr]    <= push_port.pc;
			q_instr[wr_ptr] <= push_port.instr;
			q_kind[wr_ptr]  <= push_port.kind;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || redirect_valid) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_port.push) begin
				wr_ptr <= (wr_ptr == PW'(`IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PW'(`IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CW'(push_port.push) - CW'(pop);
		end
	end

	// consumer credits survive a redirect
	always_ff @(posedge clk) begin
		if (reset) begin
			out_credits <= OCW'(`OUT_CREDITS);
		end else begin
			out_credits <= out_credits - OCW'(pop) + OCW'(out_credit);
		end
	end

	always_ff @(posedge clk) begin
		if (reset || redirect_valid) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			out_pc    <= q_pc[rd_ptr];
			out_instr <= q_instr[rd_ptr];
			out_kind  <= q_kind[rd_ptr];
		end
	end

endmodule

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top
	import fetch_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	output logic        imem_req_valid,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_data,
	input  logic        redirect_valid,
	input  logic [31:0] redirect_pc,
	output logic        out_valid,
	output logic [31:0] out_pc,
	output logic [31:0] out_instr,
	output instr_kind_e out_kind,
	input  logic        out_credit
);

	logic        fetch_credit;
	logic        jump_valid;
	logic [31:0] jump_target;

	iq_push_if u_push_if ();

	pc_gen u_pc_gen (
		.clk            (clk),
		.reset          (reset),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.jump_valid     (jump_valid),
		.jump_target    (jump_target),
		.fetch_credit   (fetch_credit),
		.req_valid      (imem_req_valid),
		.req_pc         (imem_addr)
	);

	// request also feeds predecode so it can pair pc with the response
	predecode u_predecode (
		.clk            (clk),
		.reset          (reset),
		.redirect_valid (redirect_valid),
		.req_valid      (imem_req_valid),
		.req_pc         (imem_addr),
		.imem_data      (imem_data),
		.jump_valid     (jump_valid),
		.jump_target    (jump_target),
		.push_port      (u_push_if.source)
	);

	instr_queue u_instr_queue (
		.clk            (clk),
		.reset          (reset),
		.redirect_valid (redirect_valid),
		.push_port      (u_push_if.sink),
		.fetch_credit   (fetch_credit),
		.out_valid      (out_valid),
		.out_pc         (out_pc),
		.out_instr      (out_instr),
		.out_kind       (out_kind),
		.out_credit     (out_credit)
	);

endmodule

`default_nettype wire

//--- fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module fetch_checker
	import fetch_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        imem_req_valid,
	input  logic [31:0] imem_addr,
	input  logic        redirect_valid,
	input  logic [31:0] redirect_pc,
	input  logic        out_valid,
	input  logic [31:0] out_pc,
	input  logic [31:0] out_instr,
	input  instr_kind_e out_kind,
	input  logic        out_credit,
	input  logic        final_check,
	input  int          expected_total,
	output int          error_count,
	output int          output_count
);

	logic [31:0] image_word [logic [31:0]];
	logic [1:0]  image_kind [logic [31:0]];
	logic [31:0] exp_req_pc = `RESET_PC;
	logic [31:0] exp_out_pc = `RESET_PC;
	logic        reset_seen = 1'b0;
	logic        redirect_seen = 1'b0;
	int          credits_given = 0;
	int          in_flight = 0;
	int          errors = 0;
	int          outputs = 0;

	assign error_count  = errors;
	assign output_count = outputs;

	task automatic add_image_word(input logic [31:0] addr, input logic [31:0] word,
	                              input logic [1:0] kind);
		image_word[addr] = word;
		image_kind[addr] = kind;
	endtask

	// j-type target inside the 256 MB region of pc + 4
	function automatic logic [31:0] jump_dest(input logic [31:0] pc, input logic [31:0] word);
		logic [31:0] pc4;
		pc4 = pc + 32'd4;
		return {pc4[31:28], word[25:0], 2'b00};
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			// the first edge only loads the reset values
			if (reset_seen && (imem_req_valid !== 1'b0 || out_valid !== 1'b0)) begin
				$display("FAILED %0t ns: request or output valid during reset", $time);
				errors++;
			end
			reset_seen    = 1'b1;
			redirect_seen = 1'b0;
			exp_req_pc    = `RESET_PC;
			exp_out_pc    = `RESET_PC;
			in_flight     = 0;
		end else begin
			if (redirect_seen && out_valid) begin
				$display("FAILED %0t ns: out_valid high right after a redirect", $time);
				errors++;
			end
			// outputs of a redirect cycle still belong to the old path
			if (out_valid) begin
				outputs++;
				in_flight--;
				if (!image_word.exists(out_pc)) begin
					$display("FAILED %0t ns: output pc %h outside the memory image", $time, out_pc);
					errors++;
				end else begin
					if (out_pc !== exp_out_pc) begin
						$display("FAILED %0t ns: out_pc %h, expected %h", $time, out_pc, exp_out_pc);
						errors++;
					end
					if (out_instr !== image_word[out_pc] || out_kind !== image_kind[out_pc]) begin
						$display("FAILED %0t ns: pc %h gave instr %h kind %0d, expected %h kind %0d",
						         $time, out_pc, out_instr, out_kind, image_word[out_pc],
						         image_kind[out_pc]);
						errors++;
					end
					exp_out_pc = (image_kind[out_pc] == KIND_JUMP) ?
					             jump_dest(out_pc, image_word[out_pc]) : out_pc + 32'd4;
				end
			end
			if (imem_req_valid) begin
				if (imem_addr !== exp_req_pc) begin
					$display("FAILED %0t ns: request to %h, expected %h", $time, imem_addr,
					         exp_req_pc);
					errors++;
				end
				in_flight++;
				exp_req_pc = imem_addr + 32'd4;
				if (image_kind.exists(imem_addr) && image_kind[imem_addr] == KIND_JUMP) begin
					exp_req_pc = jump_dest(imem_addr, image_word[imem_addr]);
				end
			end
			if (outputs > `OUT_CREDITS + credits_given) begin
				$display("FAILED %0t ns: %0d outputs for %0d consumer credits", $time, outputs,
				         `OUT_CREDITS + credits_given);
				errors++;
			end
			if (out_credit) begin
				credits_given++;
			end
			if (in_flight > `IQ_DEPTH) begin
				$display("FAILED %0t ns: %0d instructions in flight", $time, in_flight);
				errors++;
			end
			if (redirect_valid) begin
				exp_req_pc = redirect_pc;
				exp_out_pc = redirect_pc;
				in_flight  = 0;
			end
			redirect_seen = redirect_valid;
			if (final_check && outputs != expected_total) begin
				$display("FAILED %0t ns: %0d outputs, expected %0d", $time, outputs,
				         expected_total);
				errors++;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module tb_fetch
	import fetch_pkg::*;
();

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic        imem_req_valid;
	logic [31:0] imem_addr;
	logic [31:0] imem_data = '0;
	logic        redirect_valid = 1'b0;
	logic [31:0] redirect_pc = '0;
	logic        out_valid;
	logic [31:0] out_pc;
	logic [31:0] out_instr;
	instr_kind_e out_kind;
	logic        out_credit = 1'b0;
	logic        final_check = 1'b0;
	int          expected_total = 0;
	int          error_count;
	int          output_count;

	logic [31:0] mem [logic [31:0]];
	int          redir_cycle [$];
	logic [31:0] redir_target [$];
	int          cycle = 0;
	int          buffered = 0;
	int          credit_total = `OUT_CREDITS;
	int          run_errors = 0;

	fetch_top u_fetch_top (.*);

	fetch_checker u_checker (.*);

	always #50 clk = ~clk;

	// unlisted words get an address-dependent filler with opcode 6'h3f
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {6'h3f, addr[31:6] ^ addr[25:0]};
	endfunction

	// instruction memory answers one cycle after the request
	always @(posedge clk) begin
		if (imem_req_valid) begin
			imem_data <= mem.exists(imem_addr) ? mem[imem_addr] : fill_word(imem_addr);
		end
	end

	// redirects fire on cycles counted from the end of reset
	always @(posedge clk) begin
		redirect_valid <= 1'b0;
		if (reset) begin
			cycle = 0;
		end else begin
			cycle = cycle + 1;
			if (redir_cycle.size() > 0 && redir_cycle[0] == cycle) begin
				redirect_valid <= 1'b1;
				redirect_pc    <= redir_target.pop_front();
				redir_cycle.delete(0);
			end
		end
	end

	// consumer drains its buffer at random and returns one credit per drained entry
	// alternating fast and slow phases to stress back-pressure
	always @(posedge clk) begin
		out_credit <= 1'b0;
		if (reset) begin
			buffered = 0;
		end else begin
			if (out_valid) begin
				buffered = buffered + 1;
			end
			if (buffered > 0 && credit_total < expected_total &&
			    ($urandom % 8) < ((credit_total % 40 < 20) ? 6 : 1)) begin
				buffered = buffered - 1;
				credit_total = credit_total + 1;
				out_credit <= 1'b1;
			end
		end
	end

	initial begin
		int          fd;
		int          n;
		int          k;
		int          wait_cycles;
		string       line;
		logic [31:0] a;
		logic [31:0] b;
		void'($urandom(22));
		fd = $fopen("fetch_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open fetch_vectors.txt");
			run_errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.getc(0) == "M") begin
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h %d", a, b, k);
					if (n != 3) begin
						$display("malformed M line in fetch_vectors.txt");
						run_errors++;
					end else begin
						mem[a] = b;
						u_checker.add_image_word(a, b, k[1:0]);
					end
				end else if (line.getc(0) == "R") begin
					n = $sscanf(line.substr(1, line.len() - 1), "%d %h", k, a);
					if (n != 2) begin
						$display("malformed R line in fetch_vectors.txt");
						run_errors++;
					end else begin
						redir_cycle.push_back(k);
						redir_target.push_back(a);
					end
				end else if (line.getc(0) == "N") begin
					n = $sscanf(line.substr(1, line.len() - 1), "%d", k);
					if (n != 1) begin
						$display("malformed N line in fetch_vectors.txt");
						run_errors++;
					end else begin
						expected_total = k;
					end
				end
			end
			$fclose(fd);
			repeat (2) @(posedge clk);
			reset <= 1'b0;
			wait_cycles = 0;
			while (redir_cycle.size() > 0 && wait_cycles < 2000) begin
				@(negedge clk);
				wait_cycles++;
			end
			if (redir_cycle.size() > 0) begin
				$display("timeout: redirect events still pending after %0d cycles", wait_cycles);
				run_errors++;
			end else begin
				wait_cycles = 0;
				while (output_count < expected_total && wait_cycles < 4000) begin
					@(negedge clk);
					wait_cycles++;
				end
				if (output_count < expected_total) begin
					$display("timeout: only %0d of %0d outputs arrived", output_count,
					         expected_total);
					run_errors++;
				end else begin
					// idle window so that any extra output would show up
					repeat (20) @(posedge clk);
					final_check <= 1'b1;
					@(posedge clk);
					final_check <= 1'b0;
					@(negedge clk);
				end
			end
		end
		$display("errors: checker %0d, run %0d, outputs %0d of %0d", error_count, run_errors,
		         output_count, expected_total);
		if (error_count == 0 && run_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- fetch_vectors.txt
# M <address hex> <instruction hex> <kind: 0 seq, 1 jump, 2 branch>
# R <cycle after reset> <redirect pc hex>, N <expected number of outputs>
M 00000100 20010001 0
M 00000104 20020002 0
M 00000108 10220003 2
M 0000010c 20030003 0
M 00000110 08000080 1
M 00000114 20040004 0
M 00000200 20050005 0
M 00000204 1445ffff 2
M 00000208 0c0000c0 1
M 00000300 20060006 0
M 00000304 20070007 0
M 00000308 08000040 1
M 00000400 20080008 0
M 00000404 10000001 2
M 00000408 20090009 0
M 0000040c 08000040 1
R 40 00000400
R 90 00000204
R 91 00000300
R 300 0000010c
N 150

//--- flist.f
+incdir+.
fetch_pkg.sv
iq_push_if.sv
pc_gen.sv
predecode.sv
instr_queue.sv
fetch_top.sv
fetch_checker.sv
tb_fetch.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module tb_fetch -f flist.f -o sim_fetch
./obj_dir/sim_fetch | tee sim.log
if grep -qF "*** TEST PASSED ***" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
